// File: common/core_config.svh
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// Byte address width seen by both memories
`define CORE_ADDR_W 12

// Fetch address out of reset
`define CORE_RESET_PC 32'h0000_0000

// Halt pair, addi x1,x0,12 then jalr x0,0(x1)
`define CORE_HALT_WORD0 32'h00c0_0093
`define CORE_HALT_WORD1 32'h0000_8067

`endif

// File: common/rvIsaPkg.sv
package rvIsaPkg;

	// RV32I major opcodes, only the ones this core executes
	typedef enum logic [6:0] {
		opcLoad   = 7'b0000011,
		opcOpImm  = 7'b0010011,
		opcAuipc  = 7'b0010111,
		opcStore  = 7'b0100011,
		opcOp     = 7'b0110011,
		opcLui    = 7'b0110111,
		opcBranch = 7'b1100011,
		opcJalr   = 7'b1100111,
		opcJal    = 7'b1101111
	} opcodeT;

	// Compare ops return 0 or 1 in bit 0
	typedef enum logic [3:0] {
		aluAdd, aluSub, aluSll, aluSlt, aluSltu, aluXor, aluSrl,
		aluSra, aluOr, aluAnd, aluEq, aluNe, aluGe, aluGeu
	} aluOpT;

	// Load and store width codes
	localparam logic [2:0] f3Byte  = 3'b000;
	localparam logic [2:0] f3Half  = 3'b001;
	localparam logic [2:0] f3Word  = 3'b010;
	localparam logic [2:0] f3ByteU = 3'b100; // Zero extended
	localparam logic [2:0] f3HalfU = 3'b101;

	// Branch conditions
	localparam logic [2:0] f3Beq  = 3'b000;
	localparam logic [2:0] f3Bne  = 3'b001;
	localparam logic [2:0] f3Blt  = 3'b100;
	localparam logic [2:0] f3Bge  = 3'b101;
	localparam logic [2:0] f3Bltu = 3'b110;
	localparam logic [2:0] f3Bgeu = 3'b111;

	// Register and immediate arithmetic
	localparam logic [2:0] f3AddSub = 3'b000;
	localparam logic [2:0] f3Sll    = 3'b001;
	localparam logic [2:0] f3Slt    = 3'b010;
	localparam logic [2:0] f3Sltu   = 3'b011;
	localparam logic [2:0] f3Xor    = 3'b100;
	localparam logic [2:0] f3SrlSra = 3'b101; // instr[30] picks arithmetic
	localparam logic [2:0] f3Or     = 3'b110;
	localparam logic [2:0] f3And    = 3'b111;

endpackage

// File: common/rvCtrlPkg.sv
package rvCtrlPkg;

	// Source of the register write-back value
	typedef enum logic [1:0] {
		wbAlu,
		wbLoad,
		wbPc4, // Link address for JAL and JALR
		wbImm  // LUI
	} wbSelT;

	// Next PC source
	typedef enum logic [1:0] {
		pcSeq,
		pcBranch, // PC plus immediate, also JAL
		pcJump    // JALR, from the ALU
	} pcSelT;

	// Halt pair detector
	typedef enum logic [1:0] {
		hsRun,
		hsFirst,
		hsHalted
	} haltStateT;

endpackage

// File: rtl/decoder.sv
`timescale 1ns/1ps

module decoder import rvIsaPkg::*, rvCtrlPkg::*; (
	input logic [31:0] instr,
	output logic [4:0] rs1,
	output logic [4:0] rs2,
	output logic [4:0] rd,
	output logic [31:0] imm,
	output aluOpT aluOp,
	output logic aluSrcImm,
	output logic aluSrcPc,
	output wbSelT wbSel,
	output logic regWrite,
	output logic memWrite,
	output logic [2:0] memFunct,
	output logic isBranch,
	output logic isJal,
	output logic isJalr
);

	opcodeT opcode;
	logic [2:0] funct3;
	logic [31:0] immI, immS, immB, immU, immJ;

	// Shared by OP and OP-IMM, subBit only ever set for OP
	function automatic aluOpT arithOp(input logic [2:0] f3, input logic subBit,
		input logic sraBit);
		case (f3)
			f3AddSub: arithOp = subBit ? aluSub : aluAdd;
			f3Sll:    arithOp = aluSll;
			f3Slt:    arithOp = aluSlt;
			f3Sltu:   arithOp = aluSltu;
			f3Xor:    arithOp = aluXor;
			f3SrlSra: arithOp = sraBit ? aluSra : aluSrl;
			f3Or:     arithOp = aluOr;
			f3And:    arithOp = aluAnd;
			default:  arithOp = aluAdd;
		endcase
	endfunction

	assign opcode = opcodeT'(instr[6:0]);
	assign funct3 = instr[14:12];
	assign rs1 = instr[19:15];
	assign rs2 = instr[24:20];
	assign rd = instr[11:7];
	assign memFunct = funct3; // Width code for the aligner

	// Sign-extended immediates, one per format
	assign immI = {{20{instr[31]}}, instr[31:20]};
	assign immS = {{20{instr[31]}}, instr[31:25], instr[11:7]};
	assign immB = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
	assign immU = {instr[31:12], 12'b0};
	assign immJ = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

	always_comb begin
		imm = immI;
		aluOp = aluAdd;
		wbSel = wbAlu;
		aluSrcImm = 1'b0;
		aluSrcPc = 1'b0;
		regWrite = 1'b0; // Unknown opcodes write nothing
		memWrite = 1'b0;
		isBranch = 1'b0;
		isJal = 1'b0;
		isJalr = 1'b0;
		case (opcode)
			opcOp: begin
				aluOp = arithOp(funct3, instr[30], instr[30]);
				regWrite = 1'b1;
			end
			opcOpImm: begin
				aluOp = arithOp(funct3, 1'b0, instr[30]);
				aluSrcImm = 1'b1;
				regWrite = 1'b1;
			end
			opcLoad: begin
				aluSrcImm = 1'b1; // Address is rs1 plus offset
				wbSel = wbLoad;
				regWrite = 1'b1;
			end
			opcStore: begin
				imm = immS;
				aluSrcImm = 1'b1;
				memWrite = 1'b1;
			end
			opcBranch: begin
				imm = immB;
				isBranch = 1'b1;
				case (funct3)
					f3Beq:   aluOp = aluEq;
					f3Bne:   aluOp = aluNe;
					f3Blt:   aluOp = aluSlt;
					f3Bge:   aluOp = aluGe;
					f3Bltu:  aluOp = aluSltu;
					f3Bgeu:  aluOp = aluGeu;
					default: isBranch = 1'b0; // Reserved condition, fall through
				endcase
			end
			opcJal: begin
				imm = immJ;
				wbSel = wbPc4;
				regWrite = 1'b1;
				isJal = 1'b1;
			end
			opcJalr: begin
				aluSrcImm = 1'b1; // Target rs1 plus offset
				wbSel = wbPc4;
				regWrite = 1'b1;
				isJalr = 1'b1;
			end
			opcLui: begin
				imm = immU;
				wbSel = wbImm;
				regWrite = 1'b1;
			end
			opcAuipc: begin
				imm = immU;
				aluSrcPc = 1'b1;
				aluSrcImm = 1'b1;
				regWrite = 1'b1;
			end
			default: ;
		endcase
	end

endmodule

// File: rtl/alu.sv
`timescale 1ns/1ps

module alu import rvIsaPkg::*; (
	input logic [31:0] a,
	input logic [31:0] b,
	input aluOpT op,
	output logic [31:0] result
);

	logic [4:0] shamt;

	assign shamt = b[4:0]; // RV32I uses five shift bits only

	always_comb begin
		case (op)
			aluAdd:  result = a + b;
			aluSub:  result = a - b;
			aluSll:  result = a << shamt;
			aluSlt:  result = {31'b0, $signed(a) < $signed(b)};
			aluSltu: result = {31'b0, a < b};
			aluXor:  result = a ^ b;
			aluSrl:  result = a >> shamt;
			aluSra:  result = $signed(a) >>> shamt; // Keeps sign
			aluOr:   result = a | b;
			aluAnd:  result = a & b;
			// Branch compares, bit 0 is the decision
			aluEq:   result = {31'b0, a == b};
			aluNe:   result = {31'b0, a != b};
			aluGe:   result = {31'b0, $signed(a) >= $signed(b)};
			aluGeu:  result = {31'b0, a >= b};
			default: result = a + b;
		endcase
	end

endmodule

// File: rtl/lsuAlign.sv
`timescale 1ns/1ps

module lsuAlign import rvIsaPkg::*; (
	input logic [1:0] addrLow,
	input logic [2:0] funct,
	input logic [31:0] storeData,
	input logic [31:0] memRdata,
	output logic [3:0] byteEn,
	output logic [31:0] storeWord,
	output logic [31:0] loadData
);

	logic [31:0] laneData;

	// Store side, data replicated so any lane holds it
	always_comb begin
		case (funct)
			f3Byte: begin
				storeWord = {4{storeData[7:0]}};
				byteEn = 4'b0001 << addrLow;
			end
			f3Half: begin
				storeWord = {2{storeData[15:0]}};
				byteEn = 4'b0011 << {addrLow[1], 1'b0}; // Low or high half
			end
			f3Word: begin
				storeWord = storeData;
				byteEn = 4'b1111;
			end
			default: begin
				storeWord = storeData;
				byteEn = 4'b0000; // Reserved width stores nothing
			end
		endcase
	end

	// Addressed lane moved down to bit 0
	assign laneData = memRdata >> {addrLow, 3'b000};

	always_comb begin
		case (funct)
			f3Byte:  loadData = {{24{laneData[7]}}, laneData[7:0]};
			f3ByteU: loadData = {24'b0, laneData[7:0]};
			f3Half:  loadData = {{16{laneData[15]}}, laneData[15:0]};
			f3HalfU: loadData = {16'b0, laneData[15:0]};
			default: loadData = memRdata; // LW
		endcase
	end

endmodule

// File: rtl/pcUnit.sv
`timescale 1ns/1ps
`include "core_config.svh"

module pcUnit import rvCtrlPkg::*; (
	input logic CLK,
	input logic RSTn,
	input logic advance,
	input logic branchTaken,
	input logic isJal,
	input logic isJalr,
	input logic [31:0] imm,
	input logic [31:0] aluResult,
	output logic [31:0] pc,
	output logic [31:0] pcPlus4
);

	pcSelT pcSel;
	logic [31:0] nextPc;

	assign pcPlus4 = pc + 32'd4;

	always_comb begin
		if (isJalr) pcSel = pcJump;
		else if (isJal || branchTaken) pcSel = pcBranch; // Same adder for both
		else pcSel = pcSeq;
	end

	always_comb begin
		case (pcSel)
			pcBranch: nextPc = pc + imm;
			pcJump:   nextPc = {aluResult[31:1], 1'b0}; // Bit 0 cleared per spec
			default:  nextPc = pcPlus4;
		endcase
	end

	always_ff @(posedge CLK) begin
		if (RSTn) pc <= `CORE_RESET_PC;
		else if (advance) pc <= nextPc; // Frozen once halted
	end

endmodule

// File: rtl/haltFsm.sv
`timescale 1ns/1ps
`include "core_config.svh"

module haltFsm import rvCtrlPkg::*; (
	input logic CLK,
	input logic RSTn,
	input logic [31:0] instr,
	output logic halt
);

	haltStateT state, nextState;

	// Rises in the cycle the second word shows up
	assign halt = (state == hsHalted) ||
		(state == hsFirst && instr == `CORE_HALT_WORD1);

	always_comb begin
		nextState = state;
		case (state)
			hsRun:   if (instr == `CORE_HALT_WORD0) nextState = hsFirst;
			hsFirst: nextState = (instr == `CORE_HALT_WORD1) ? hsHalted : hsRun;
			hsHalted: nextState = hsHalted; // Only reset leaves
			default: nextState = hsRun;
		endcase
	end

	always_ff @(posedge CLK) begin
		if (RSTn) state <= hsRun;
		else state <= nextState;
	end

endmodule

// File: rtl/retireCounter.sv
`timescale 1ns/1ps

module retireCounter (
	input logic CLK,
	input logic RSTn,
	input logic enable,
	output logic [31:0] count
);

	// Wraps naturally at 32 bits
	always_ff @(posedge CLK) begin
		if (RSTn) begin
			count <= 32'd0;
		end else if (enable) begin
			count <= count + 32'd1;
		end
	end

endmodule

// File: rtl/riscvTop.sv
`timescale 1ns/1ps
`include "core_config.svh"

module riscvTop import rvIsaPkg::*, rvCtrlPkg::*; (
	input logic CLK,
	input logic RSTn,
	output logic iMemCsn,
	input logic [31:0] iMemDi,
	output logic [`CORE_ADDR_W-1:0] iMemAddr, // Byte address
	output logic dMemCsn,
	input logic [31:0] dMemDi,
	output logic [31:0] dMemDout,
	output logic [`CORE_ADDR_W-1:0] dMemAddr, // Word address
	output logic dMemWen,
	output logic [3:0] dMemBe,
	output logic rfWe,
	output logic [4:0] rfRa1,
	output logic [4:0] rfRa2,
	output logic [4:0] rfWa1,
	input logic [31:0] rfRd1,
	input logic [31:0] rfRd2,
	output logic [31:0] rfWd,
	output logic halt,
	output logic [31:0] numInst,
	output logic [31:0] outputPort
);

	logic [31:0] imm, aluA, aluB, aluResult, loadData, pc, pcPlus4;
	aluOpT aluOp;
	wbSelT wbSel;
	logic aluSrcImm, aluSrcPc, regWrite, memWrite;
	logic isBranch, isJal, isJalr, running;
	logic [2:0] memFunct;

	assign running = !RSTn && !halt; // Out of reset and not frozen

	assign iMemCsn = RSTn;
	assign dMemCsn = RSTn;
	assign iMemAddr = pc[`CORE_ADDR_W-1:0];
	assign dMemAddr = aluResult[`CORE_ADDR_W+1:2]; // Drop byte offset

	decoder decoder_i (
		.instr(iMemDi), .rs1(rfRa1), .rs2(rfRa2), .rd(rfWa1), .imm(imm),
		.aluOp(aluOp), .aluSrcImm(aluSrcImm), .aluSrcPc(aluSrcPc), .wbSel(wbSel),
		.regWrite(regWrite), .memWrite(memWrite), .memFunct(memFunct),
		.isBranch(isBranch), .isJal(isJal), .isJalr(isJalr)
	);

	assign aluA = aluSrcPc ? pc : rfRd1; // PC only for AUIPC
	assign aluB = aluSrcImm ? imm : rfRd2;

	alu alu_i (.a(aluA), .b(aluB), .op(aluOp), .result(aluResult));

	lsuAlign lsuAlign_i (
		.addrLow(aluResult[1:0]), .funct(memFunct), .storeData(rfRd2),
		.memRdata(dMemDi), .byteEn(dMemBe), .storeWord(dMemDout), .loadData(loadData)
	);

	pcUnit pcUnit_i (
		.CLK(CLK), .RSTn(RSTn), .advance(!halt),
		.branchTaken(isBranch && aluResult[0]), // Compare result in bit 0
		.isJal(isJal), .isJalr(isJalr), .imm(imm), .aluResult(aluResult),
		.pc(pc), .pcPlus4(pcPlus4)
	);

	haltFsm haltFsm_i (.CLK(CLK), .RSTn(RSTn), .instr(iMemDi), .halt(halt));

	retireCounter retireCounter_i (
		.CLK(CLK), .RSTn(RSTn), .enable(running), .count(numInst)
	);

	// Write-back select
	always_comb begin
		case (wbSel)
			wbLoad:  rfWd = loadData;
			wbPc4:   rfWd = pcPlus4; // Link
			wbImm:   rfWd = imm;
			default: rfWd = aluResult;
		endcase
	end

	assign rfWe = regWrite && running;
	assign dMemWen = !(memWrite && running); // Active low
	assign outputPort = rfWd;

endmodule

// File: verification/riscvChecker.sv
`timescale 1ns/1ps
`include "core_config.svh"

module riscvChecker (
	input logic CLK,
	input logic RSTn,
	input logic iMemCsn,
	input logic dMemCsn,
	input logic [`CORE_ADDR_W-1:0] iMemAddr,
	input logic [`CORE_ADDR_W-1:0] dMemAddr,
	input logic dMemWen,
	input logic [3:0] dMemBe,
	input logic [31:0] dMemDout,
	input logic rfWe,
	input logic [4:0] rfWa1,
	input logic [31:0] rfWd,
	input logic [31:0] outputPort,
	input logic halt,
	input logic [31:0] numInst,
	output int errCount
);

	// Architectural state of the ISA model
	logic [31:0] refRegs [0:31];
	logic [31:0] refMem [0:4095];
	logic [31:0] refPc, refCount, prevWord, ins, mask;
	logic refHalted, resetSeen, expHalt;
	// Effects of the instruction at refPc
	logic expWe, expStore;
	logic [4:0] expRd;
	logic [3:0] expBe;
	logic [31:0] expWd, expAddr, expData, expNextPc;
	string cls; // Instruction class, used in error lines

	initial errCount = 0;
	initial resetSeen = 1'b0;

	task automatic checkVal(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (act !== exp) begin
			errCount++;
			$display("Error %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	// RV32I integer ops, alt is instr bit 30 where it applies
	function automatic logic [31:0] arith(input logic [2:0] f3, input logic alt,
		input logic [31:0] x, input logic [31:0] y);
		case (f3)
			3'd0: return alt ? x - y : x + y;
			3'd1: return x << y[4:0];
			3'd2: return {31'b0, $signed(x) < $signed(y)};
			3'd3: return {31'b0, x < y};
			3'd4: return x ^ y;
			3'd5: return alt ? $unsigned($signed(x) >>> y[4:0]) : x >> y[4:0];
			3'd6: return x | y;
			default: return x & y;
		endcase
	endfunction

	// One instruction of the ISA model, fills the exp* values
	function automatic void refStep(input logic [31:0] w);
		logic [31:0] a, b, immI, immS, immB, immJ, word;
		logic [1:0] off;
		logic take;
		a = refRegs[w[19:15]];
		b = refRegs[w[24:20]];
		immI = {{20{w[31]}}, w[31:20]};
		immS = {{20{w[31]}}, w[31:25], w[11:7]};
		immB = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
		immJ = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
		expRd = w[11:7];
		expWe = 1'b1;
		expStore = 1'b0;
		expWd = 32'h0;
		expNextPc = refPc + 32'd4;
		expAddr = a + ((w[6:0] == 7'h23) ? immS : immI); // Load and store address
		off = expAddr[1:0];
		expBe = 4'h0;
		expData = 32'h0;
		case (w[6:0])
			7'h33: begin
				cls = "alu reg";
				expWd = arith(w[14:12], w[30], a, b);
			end
			7'h13: begin
				cls = "alu imm";
				expWd = arith(w[14:12], w[14:12] == 3'd5 && w[30], a, immI); // Only SRAI
			end
			7'h37: begin
				cls = "lui";
				expWd = {w[31:12], 12'h0};
			end
			7'h17: begin
				cls = "auipc";
				expWd = refPc + {w[31:12], 12'h0};
			end
			7'h6f: begin
				cls = "jal";
				expWd = refPc + 32'd4; // Link
				expNextPc = refPc + immJ;
			end
			7'h67: begin
				cls = "jalr";
				expWd = refPc + 32'd4;
				expNextPc = (a + immI) & ~32'h1;
			end
			7'h63: begin
				cls = "branch";
				expWe = 1'b0;
				case (w[14:12])
					3'd0: take = a == b;
					3'd1: take = a != b;
					3'd4: take = $signed(a) < $signed(b);
					3'd5: take = $signed(a) >= $signed(b);
					3'd6: take = a < b;
					default: take = a >= b;
				endcase
				if (take) expNextPc = refPc + immB;
			end
			7'h03: begin
				cls = "load";
				word = refMem[expAddr[`CORE_ADDR_W+1:2]] >> {off, 3'b000};
				case (w[14:12])
					3'd0: expWd = {{24{word[7]}}, word[7:0]};
					3'd1: expWd = {{16{word[15]}}, word[15:0]};
					3'd4: expWd = {24'h0, word[7:0]};
					3'd5: expWd = {16'h0, word[15:0]};
					default: expWd = word;
				endcase
			end
			7'h23: begin
				cls = "store";
				expWe = 1'b0;
				expStore = 1'b1;
				case (w[14:12])
					3'd0: expBe = 4'b0001 << off;
					3'd1: expBe = 4'b0011 << off;
					default: expBe = 4'b1111;
				endcase
				expData = b << {off, 3'b000}; // Into its lanes
			end
			default: begin
				cls = "unknown";
				expWe = 1'b0;
			end
		endcase
	endfunction

	always @(posedge CLK) begin
		if (RSTn === 1'b1) resetSeen <= 1'b1; // PC defined from here on
	end

	always @(negedge CLK) begin
		if (RSTn === 1'b1 && resetSeen) begin
			checkVal("reset iMemAddr", `CORE_RESET_PC, iMemAddr);
			checkVal("reset iMemCsn", 1, iMemCsn);
			checkVal("reset dMemCsn", 1, dMemCsn);
			checkVal("reset numInst", 0, numInst);
			checkVal("reset halt", 0, halt);
			checkVal("reset dMemWen", 1, dMemWen);
			checkVal("reset rfWe", 0, rfWe);
			refPc = `CORE_RESET_PC;
			refCount = 32'd0;
			prevWord = 32'h0;
			refHalted = 1'b0;
			for (int i = 0; i < 32; i++) refRegs[i] = 32'h0;
			for (int i = 0; i < 4096; i++) refMem[i] = riscvTb.dmem[i];
		end else if (RSTn === 1'b0) begin
			ins = riscvTb.imem[refPc[`CORE_ADDR_W-1:2]];
			expHalt = refHalted || (prevWord == `CORE_HALT_WORD0 && ins == `CORE_HALT_WORD1);
			checkVal("fetch iMemAddr", refPc, iMemAddr);
			checkVal("run iMemCsn", 0, iMemCsn);
			checkVal("run dMemCsn", 0, dMemCsn);
			checkVal("halt", expHalt, halt);
			checkVal("count numInst", refCount, numInst);
			if (expHalt) begin
				checkVal("halted rfWe", 0, rfWe); // Frozen core writes nothing
				checkVal("halted dMemWen", 1, dMemWen);
				refHalted = 1'b1;
			end else begin
				refStep(ins);
				checkVal({cls, " rfWe"}, expWe, rfWe);
				if (expWe) begin
					checkVal({cls, " rfWa1"}, expRd, rfWa1);
					checkVal({cls, " rfWd"}, expWd, rfWd);
					checkVal({cls, " outputPort"}, expWd, outputPort);
				end
				checkVal({cls, " dMemWen"}, !expStore, dMemWen);
				if (expStore) begin
					// Only enabled lanes carry meaning
					mask = {{8{expBe[3]}}, {8{expBe[2]}}, {8{expBe[1]}}, {8{expBe[0]}}};
					checkVal("store dMemAddr", expAddr[`CORE_ADDR_W+1:2], dMemAddr);
					checkVal("store dMemBe", expBe, dMemBe);
					checkVal("store dMemDout", expData & mask, dMemDout & mask);
					refMem[expAddr[`CORE_ADDR_W+1:2]] =
						(refMem[expAddr[`CORE_ADDR_W+1:2]] & ~mask) | (expData & mask);
				end
				if (expWe && expRd != 5'd0) refRegs[expRd] = expWd;
				refPc = expNextPc;
				refCount = refCount + 32'd1;
				prevWord = ins;
			end
		end
	end

endmodule

// File: verification/riscvTb.sv
`timescale 1ns/1ps
`include "core_config.svh"

module riscvTb;

	logic CLK;
	logic RSTn;
	logic iMemCsn, dMemCsn, dMemWen, rfWe, halt;
	logic [31:0] iMemDi, dMemDi, dMemDout, rfRd1, rfRd2, rfWd, numInst, outputPort;
	logic [`CORE_ADDR_W-1:0] iMemAddr, dMemAddr;
	logic [3:0] dMemBe;
	logic [4:0] rfRa1, rfRa2, rfWa1;
	logic [31:0] imem [0:1023]; // Word indexed
	logic [31:0] dmem [0:4095];
	logic [31:0] rf [0:31];
	integer seed;
	int errCount;
	int timeoutCount;
	int progIdx;
	int cycles;

	riscvTop riscvTop_i (.*);
	riscvChecker riscvChecker_i (.*);

	initial CLK = 1'b0;
	always #50 CLK = ~CLK; // 100 ns period

	// Combinational reads, x0 hardwired
	assign iMemDi = imem[iMemAddr[`CORE_ADDR_W-1:2]];
	assign dMemDi = dmem[dMemAddr];
	assign rfRd1 = (rfRa1 == 5'd0) ? 32'h0 : rf[rfRa1];
	assign rfRd2 = (rfRa2 == 5'd0) ? 32'h0 : rf[rfRa2];

	always @(posedge CLK) begin
		if (rfWe && rfWa1 != 5'd0) rf[rfWa1] <= rfWd;
		if (!dMemCsn && !dMemWen) begin
			for (int b = 0; b < 4; b++) begin
				if (dMemBe[b]) dmem[dMemAddr][8*b +: 8] <= dMemDout[8*b +: 8];
			end
		end
	end

	function automatic logic [31:0] rType(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, 7'h33};
	endfunction

	function automatic logic [31:0] iType(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic logic [31:0] sType(input logic [11:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'h23};
	endfunction

	// Branch over the next instruction, offset +8
	function automatic logic [31:0] skipBranch(input logic [2:0] f3, input logic [4:0] rs1,
		input logic [4:0] rs2);
		return {7'b0, rs2, rs1, f3, 5'b01000, 7'h63};
	endfunction

	task automatic put(input logic [31:0] w);
		imem[progIdx] = w;
		progIdx++;
	endtask

	task automatic loadProgram();
		logic [31:0] r;
		logic [31:0] bump;
		logic [4:0] rd;
		bump = iType(12'd1, 5'd5, 3'd0, 5'd5, 7'h13); // addi x5,x5,1 as filler
		progIdx = 0;
		r = $random(seed);
		put({r[31:12], 5'd2, 7'h37}); // lui x2
		r = $random(seed);
		put(iType(r[11:0], 5'd2, 3'd0, 5'd2, 7'h13));
		r = $random(seed);
		put(iType(r[11:0], 5'd0, 3'd0, 5'd3, 7'h13));
		rd = 5'd4;
		for (int f = 0; f < 8; f++) begin
			put(rType(7'h00, 5'd3, 5'd2, f[2:0], rd)); // Every OP funct3
			rd = rd + 5'd1;
		end
		put(rType(7'h20, 5'd3, 5'd2, 3'd0, 5'd12)); // sub
		put(rType(7'h20, 5'd3, 5'd2, 3'd5, 5'd13)); // sra
		rd = 5'd14;
		for (int f = 0; f < 8; f++) begin
			r = $random(seed);
			if (f == 1 || f == 5) r[11:5] = 7'h00; // Shift immediates
			put(iType(r[11:0], 5'd2, f[2:0], rd, 7'h13));
			rd = rd + 5'd1;
		end
		r = $random(seed);
		put(iType({7'h20, r[4:0]}, 5'd2, 3'd5, 5'd22, 7'h13)); // srai
		r = $random(seed);
		put({r[31:12], 5'd23, 7'h17}); // auipc x23
		put(`CORE_HALT_WORD0); // First halt word alone
		put(iType(12'd256, 5'd0, 3'd0, 5'd24, 7'h13)); // Data base
		put(sType(12'd0, 5'd2, 5'd24, 3'd2));
		put(sType(12'd6, 5'd3, 5'd24, 3'd1)); // Upper half
		put(sType(12'd9, 5'd4, 5'd24, 3'd0));
		put(sType(12'd15, 5'd9, 5'd24, 3'd0));
		put(iType(12'd0, 5'd24, 3'd2, 5'd25, 7'h03)); // lw
		put(iType(12'd6, 5'd24, 3'd1, 5'd26, 7'h03)); // lh
		put(iType(12'd4, 5'd24, 3'd5, 5'd27, 7'h03)); // lhu
		put(iType(12'd9, 5'd24, 3'd0, 5'd28, 7'h03)); // lb
		put(iType(12'd15, 5'd24, 3'd4, 5'd29, 7'h03)); // lbu
		put(iType(12'd130, 5'd24, 3'd0, 5'd30, 7'h03)); // Random data
		put(iType(12'd66, 5'd24, 3'd5, 5'd31, 7'h03));
		put(skipBranch(3'd0, 5'd2, 5'd2)); // Always taken
		put(bump);
		for (int f = 0; f < 8; f++) begin
			if (f != 2 && f != 3) begin
				put(skipBranch(f[2:0], 5'd3, 5'd2));
				put(bump);
			end
		end
		put(32'h0080_036f); // jal x6, +8
		put(bump);
		put({20'h0, 5'd7, 7'h17}); // auipc x7, 0
		put(iType(12'd13, 5'd7, 3'd0, 5'd8, 7'h67)); // Odd target, bit 0 dropped
		put(bump);
		put(`CORE_HALT_WORD0);
		put(`CORE_HALT_WORD1);
		put(sType(12'd0, 5'd2, 5'd0, 3'd2)); // Past the halt, never runs
	endtask

	initial begin
		RSTn = 1'b1;
		seed = 32'h40047763;
		timeoutCount = 0;
		for (int i = 0; i < 32; i++) rf[i] = 32'h0;
		for (int i = 0; i < 4096; i++) dmem[i] = $random(seed);
		loadProgram();
		repeat (2) @(posedge CLK);
		RSTn <= 1'b0;
		cycles = 0;
		do begin
			@(negedge CLK);
			cycles++;
		end while (halt !== 1'b1 && cycles < 200);
		if (halt !== 1'b1) begin
			$display("Timeout: the core never halted after the program ended");
			timeoutCount++;
		end
		cycles = 0;
		while (cycles < 5) begin
			@(posedge CLK); // Frozen core stays under watch
			cycles++;
		end
		$display("Summary: %0d value mismatches, %0d timeouts", errCount, timeoutCount);
		if (errCount == 0 && timeoutCount == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

// File: riscvCore.f
+incdir+common
common/rvIsaPkg.sv
common/rvCtrlPkg.sv
rtl/decoder.sv
rtl/alu.sv
rtl/lsuAlign.sv
rtl/pcUnit.sv
rtl/haltFsm.sv
rtl/retireCounter.sv
rtl/riscvTop.sv
verification/riscvChecker.sv
verification/riscvTb.sv

// File: Bender.yml
package:
  name: riscvCore

sources:
  - include_dirs:
      - common
    files:
      - common/rvIsaPkg.sv
      - common/rvCtrlPkg.sv
      - rtl/decoder.sv
      - rtl/alu.sv
      - rtl/lsuAlign.sv
      - rtl/pcUnit.sv
      - rtl/haltFsm.sv
      - rtl/retireCounter.sv
      - rtl/riscvTop.sv
  - target: test
    include_dirs:
      - common
    files:
      - verification/riscvChecker.sv
      - verification/riscvTb.sv
